// File: hw/tlu_pkg.sv
// shared TLU controller types: state and mode enums, widths, fixed timing constants

package tlu_pkg;

    // controller states
    typedef enum logic [2:0] {
        idle              = 3'd0,
        wait_trigger_low  = 3'd1,
        send_tlu_clock    = 3'd2,
        wait_before_latch = 3'd3,
        latch_data        = 3'd4,
        wait_ack          = 3'd5
    } tlu_state_e;

    // trigger source and handshake selection
    typedef enum logic [1:0] {
        ext_flag_0         = 2'd0,
        ext_flag_1         = 2'd1,
        tlu_no_handshake   = 2'd2,  // trigger line, wait for low
        tlu_data_handshake = 2'd3   // trigger line plus serial number readback
    } tlu_mode_e;

    // record word and trigger counter
    localparam int DATA_W = 32;

    // clock cycles sent to the TLU when the configured count is zero
    localparam int TRIG_NUM_BITS = 32;

    // short scintillator pulses can glitch the TLU line
    localparam int GLITCH_WAIT_CYCLES = 5;

    // two-stage sync plus one, minimum before the latch
    localparam int SYNC_LATCH_CYCLES = 3;

    // configuration field widths
    localparam int CYCLES_W  = 5;  // tlu_trigger_clock_cycles
    localparam int DELAY_W   = 4;  // tlu_trigger_data_delay
    localparam int TIMEOUT_W = 8;  // tlu_trigger_low_time_out

endpackage

// File: hw/tlu_sequencer.sv
// trigger FSM with registered busy, clock enable, accepted and record write strobes

module tlu_sequencer
    import tlu_pkg::*;
#(
    parameter int DIVISOR = 8
) (
    input  logic                TRIGGER_CLK,
    input  logic                RESET,
    input  logic                trigger,
    input  logic                trigger_flag,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    input  tlu_mode_e           tlu_mode,
    input  logic [CYCLES_W-1:0] tlu_trigger_clock_cycles,
    input  logic [DELAY_W-1:0]  tlu_trigger_data_delay,
    input  int unsigned         phase_count,
    input  logic                low_timeout_error,
    output tlu_state_e          state,
    output logic                trigger_accepted,
    output logic                record_write,
    output logic                tlu_busy,
    output logic                tlu_clock_enable
);

    tlu_state_e  next_state;
    logic        ack_seen;      // acknowledge remembered since leaving idle
    logic        line_mode;     // modes that watch the TLU trigger line
    logic        take_trigger;
    logic        line_released;
    int unsigned clock_target;
    int unsigned latch_target;

    assign line_mode = (tlu_mode == tlu_no_handshake) || (tlu_mode == tlu_data_handshake);

    assign take_trigger = !trigger_acknowledge && trigger_enable &&
                          (trigger_flag || (trigger && line_mode));

    // low line or timed out, and past the glitch window
    assign line_released = (!trigger || low_timeout_error) &&
                           (phase_count >= GLITCH_WAIT_CYCLES);

    // zero clock cycles means the full 32
    assign clock_target = ((tlu_trigger_clock_cycles == '0) ? TRIG_NUM_BITS :
                           int'(tlu_trigger_clock_cycles)) * DIVISOR;

    assign latch_target = int'(tlu_trigger_data_delay) + SYNC_LATCH_CYCLES;

    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (take_trigger)
                    next_state = wait_trigger_low;
            end
            wait_trigger_low:
            begin
                case (tlu_mode)
                    ext_flag_0, ext_flag_1: next_state = latch_data;  // no line to wait for
                    tlu_no_handshake:
                    begin
                        if (line_released)
                            next_state = latch_data;
                    end
                    default:
                    begin
                        if (line_released)
                            next_state = send_tlu_clock;
                    end
                endcase
            end
            send_tlu_clock:
            begin
                // phase_count starts at 0, so this is the last clocked cycle
                if (phase_count >= clock_target - 1)
                    next_state = wait_before_latch;
            end
            wait_before_latch:
            begin
                if (phase_count >= latch_target - 1)
                    next_state = latch_data;
            end
            latch_data:
                next_state = wait_ack;
            wait_ack:
            begin
                if (trigger_acknowledge || ack_seen)
                    next_state = idle;
            end
            default:
                next_state = idle;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            state <= idle;
        else
            state <= next_state;
    end

    // ack may come early, keep it until the machine is back in idle
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || state == idle)
            ack_seen <= 1'b0;
        else if (trigger_acknowledge)
            ack_seen <= 1'b1;
    end

    // outputs lag the state register by one cycle
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_accepted <= 1'b0;
            record_write     <= 1'b0;
            tlu_busy         <= 1'b0;
            tlu_clock_enable <= 1'b0;
        end
        else
        begin
            // first cycle out of idle
            trigger_accepted <= (state == wait_trigger_low) && (phase_count == 0);
            record_write     <= (state == latch_data);
            tlu_clock_enable <= (state == send_tlu_clock);
            // drop busy as soon as the ack is seen in wait_ack
            tlu_busy         <= (state != idle) &&
                                !((state == wait_ack) && (trigger_acknowledge || ack_seen));
        end
    end

endmodule

// File: hw/tlu_phase_timer.sv
// shared phase counter restarting on each state change, sticky low-timeout error flag

module tlu_phase_timer
    import tlu_pkg::*;
#(
    parameter int DIVISOR = 8
) (
    input  logic                 TRIGGER_CLK,
    input  logic                 RESET,
    input  tlu_state_e           state,
    input  logic [TIMEOUT_W-1:0] tlu_trigger_low_time_out,
    output int unsigned          phase_count,
    output logic                 low_timeout_error
);

    // longest phase is the clock burst or the full timeout range
    localparam int unsigned PHASE_MAX = TRIG_NUM_BITS * DIVISOR + 2 ** TIMEOUT_W;

    tlu_state_e  last_state;
    int unsigned count_q;
    logic        timeout_hit;

    // zero in the first cycle of every state
    assign phase_count = (state != last_state) ? 0 : count_q;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            last_state <= idle;
            count_q    <= 0;
        end
        else
        begin
            last_state <= state;
            if (phase_count < PHASE_MAX)
                count_q <= phase_count + 1;
            else
                count_q <= phase_count;  // hold, a long idle must not wrap
        end
    end

    // a zero timeout field disables the check
    assign timeout_hit = (state == wait_trigger_low) &&
                         (tlu_trigger_low_time_out != '0) &&
                         (phase_count >= tlu_trigger_low_time_out);

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || state == idle)
            low_timeout_error <= 1'b0;
        else if (timeout_hit)
            low_timeout_error <= 1'b1;
    end

endmodule

// File: hw/tlu_number_deserializer.sv
// trigger line history shift register and TLU trigger number extraction at latch

module tlu_number_deserializer
    import tlu_pkg::*;
#(
    parameter int DIVISOR = 8
) (
    input  logic                TRIGGER_CLK,
    input  logic                RESET,
    input  logic                trigger,
    input  logic                record_write,
    input  logic [CYCLES_W-1:0] tlu_trigger_clock_cycles,
    input  logic                tlu_trigger_data_msb_first,
    output logic [DATA_W-1:0]   trigger_number
);

    // room for the longest burst, one sample per TRIGGER_CLK
    localparam int HIST_W = TRIG_NUM_BITS * DIVISOR;

    logic [HIST_W-1:0] line_history;  // bit 0 is the newest sample
    logic [DATA_W-1:0] number_next;
    int                num_periods;

    always_ff @(posedge TRIGGER_CLK)
    begin
        line_history <= {line_history[HIST_W-2:0], trigger};
    end

    assign num_periods = (tlu_trigger_clock_cycles == '0) ? TRIG_NUM_BITS :
                         int'(tlu_trigger_clock_cycles);

    // period p counted back from the latch sits at line_history[p*DIVISOR +: DIVISOR],
    // its last sample at p*DIVISOR; the oldest period is the start bit
    always_comb
    begin
        number_next = '0;
        for (int n = 0; n < DATA_W; n++)
        begin
            if (n < num_periods - 1)
            begin
                if (tlu_trigger_data_msb_first)
                    number_next[n] = line_history[n * DIVISOR];  // lsb arrived last
                else
                    number_next[n] = line_history[(num_periods - 2 - n) * DIVISOR];
            end
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_number <= '0;
        else if (record_write)
            trigger_number <= number_next;
    end

endmodule

// File: hw/trigger_record.sv
// timestamp, presettable trigger counter, latched record fields and output word select

module trigger_record
    import tlu_pkg::*;
(
    input  logic              TRIGGER_CLK,
    input  logic              RESET,
    input  logic              tlu_reset_flag,
    input  logic              trigger_accepted,
    input  logic              trigger_counter_set,
    input  logic [DATA_W-1:0] trigger_counter_set_value,
    input  logic [DATA_W-1:0] trigger_number,
    input  logic              record_write,
    input  logic              write_timestamp,
    input  tlu_mode_e         tlu_mode,
    output logic [DATA_W-1:0] timestamp,
    output logic [DATA_W-1:0] trigger_data
);

    logic [DATA_W-1:0] trigger_count;
    logic [DATA_W-1:0] timestamp_field;
    logic [DATA_W-1:0] count_field;
    logic [DATA_W-1:0] record_word;
    logic              sel_timestamp;
    logic              sel_number;

    // free running, cleared only by the TLU reset
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_count <= '0;
        else if (trigger_counter_set)
            trigger_count <= trigger_counter_set_value;  // preset wins
        else if (trigger_accepted)
            trigger_count <= trigger_count + 1'b1;
    end

    // snapshot closest to the trigger
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            timestamp_field <= '0;
            count_field     <= '0;
        end
        else if (trigger_accepted)
        begin
            timestamp_field <= timestamp;
            count_field     <= trigger_count;
        end
    end

    // word source fixed when the record is written
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            sel_timestamp <= 1'b0;
            sel_number    <= 1'b0;
        end
        else if (record_write)
        begin
            sel_timestamp <= write_timestamp;
            sel_number    <= (tlu_mode == tlu_data_handshake);
        end
    end

    always_comb
    begin
        if (sel_timestamp)
            record_word = timestamp_field;
        else if (sel_number)
            record_word = trigger_number;
        else
            record_word = count_field;
    end

    assign trigger_data = {1'b1, record_word[DATA_W-2:0]};  // bit 31 marks a trigger word

endmodule

// File: hw/tlu_controller.sv
// TLU controller top: sequencer, phase timer, number deserializer and record block

module tlu_controller
    import tlu_pkg::*;
#(
    parameter int DIVISOR = 8  // TRIGGER_CLK cycles per TLU clock period
) (
    input  logic                 TRIGGER_CLK,
    input  logic                 RESET,
    input  logic                 trigger,
    input  logic                 trigger_flag,
    input  logic                 trigger_enable,
    input  logic                 trigger_acknowledge,
    input  tlu_mode_e            tlu_mode,
    input  logic [TIMEOUT_W-1:0] tlu_trigger_low_time_out,
    input  logic [CYCLES_W-1:0]  tlu_trigger_clock_cycles,
    input  logic [DELAY_W-1:0]   tlu_trigger_data_delay,
    input  logic                 tlu_trigger_data_msb_first,
    input  logic                 tlu_reset_flag,
    input  logic                 write_timestamp,
    input  logic                 trigger_counter_set,
    input  logic [DATA_W-1:0]    trigger_counter_set_value,
    output logic                 trigger_data_write,
    output logic [DATA_W-1:0]    trigger_data,
    output logic                 trigger_accepted_flag,
    output logic                 tlu_busy,
    output logic                 tlu_clock_enable,
    output logic                 tlu_trigger_low_timeout_error,
    output logic [DATA_W-1:0]    timestamp
);

    tlu_state_e        state;
    int unsigned       phase_count;
    logic [DATA_W-1:0] trigger_number;

    tlu_sequencer #(
        .DIVISOR (DIVISOR)
    ) sequencer0 (
        .TRIGGER_CLK              (TRIGGER_CLK),
        .RESET                    (RESET),
        .trigger                  (trigger),
        .trigger_flag             (trigger_flag),
        .trigger_enable           (trigger_enable),
        .trigger_acknowledge      (trigger_acknowledge),
        .tlu_mode                 (tlu_mode),
        .tlu_trigger_clock_cycles (tlu_trigger_clock_cycles),
        .tlu_trigger_data_delay   (tlu_trigger_data_delay),
        .phase_count              (phase_count),
        .low_timeout_error        (tlu_trigger_low_timeout_error),
        .state                    (state),
        .trigger_accepted         (trigger_accepted_flag),
        .record_write             (trigger_data_write),
        .tlu_busy                 (tlu_busy),
        .tlu_clock_enable         (tlu_clock_enable)
    );

    tlu_phase_timer #(
        .DIVISOR (DIVISOR)
    ) phase_timer0 (
        .TRIGGER_CLK              (TRIGGER_CLK),
        .RESET                    (RESET),
        .state                    (state),
        .tlu_trigger_low_time_out (tlu_trigger_low_time_out),
        .phase_count              (phase_count),
        .low_timeout_error        (tlu_trigger_low_timeout_error)
    );

    // serial trigger number comes back on the trigger line
    tlu_number_deserializer #(
        .DIVISOR (DIVISOR)
    ) deserializer0 (
        .TRIGGER_CLK                (TRIGGER_CLK),
        .RESET                      (RESET),
        .trigger                    (trigger),
        .record_write               (trigger_data_write),
        .tlu_trigger_clock_cycles   (tlu_trigger_clock_cycles),
        .tlu_trigger_data_msb_first (tlu_trigger_data_msb_first),
        .trigger_number             (trigger_number)
    );

    trigger_record record0 (
        .TRIGGER_CLK               (TRIGGER_CLK),
        .RESET                     (RESET),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_accepted          (trigger_accepted_flag),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .trigger_number            (trigger_number),
        .record_write              (trigger_data_write),
        .write_timestamp           (write_timestamp),
        .tlu_mode                  (tlu_mode),
        .timestamp                 (timestamp),
        .trigger_data              (trigger_data)
    );

endmodule

// File: dv/tlu_tb_model.svh
// testbench reference model: Galois LFSR, TLU serial bit order, number packing, record word

`ifndef TLU_TB_MODEL_SVH
`define TLU_TB_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1, shifted right
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
        next = next ^ 32'h8020_0003;
    return next;
endfunction

// data bits carried by one TLU burst, start period excluded
function automatic int tlu_bits(input logic [4:0] cycles);
    return ((cycles == 5'd0) ? TRIG_NUM_BITS : int'(cycles)) - 1;
endfunction

// bit d of the serial stream after the start period
function automatic logic serial_bit(input logic [31:0] number, input logic [4:0] cycles,
                                    input bit msb_first, input int d);
    if (msb_first)
        return number[tlu_bits(cycles) - 1 - d];
    return number[d];
endfunction

// word the receiver should rebuild from the serial stream
function automatic logic [31:0] packed_number(input logic [31:0] number,
                                              input logic [4:0] cycles, input bit msb_first);
    logic [31:0] word;
    int          bits;
    word = '0;
    bits = tlu_bits(cycles);
    for (int d = 0; d < bits; d++)
    begin
        if (msb_first)
            word[bits - 1 - d] = serial_bit(number, cycles, msb_first, d);
        else
            word[d] = serial_bit(number, cycles, msb_first, d);
    end
    return word;
endfunction

function automatic logic [31:0] expected_word(input tlu_mode_e mode, input bit stamp,
                                              input logic [31:0] count, input logic [31:0] ts,
                                              input logic [31:0] number,
                                              input logic [4:0] cycles, input bit msb_first);
    logic [31:0] word;
    if (stamp)
        word = ts;
    else if (mode == tlu_data_handshake)
        word = packed_number(number, cycles, msb_first);
    else
        word = count;
    word[31] = 1'b1;  // trigger word marker
    return word;
endfunction

`endif

// File: dv/tb_tlu_controller.sv
// testbench for the TLU controller: clock, reset, TLU line model, stimulus, record compare

module tb_tlu_controller
    import tlu_pkg::*;
();

    localparam int DIVISOR   = 8;
    localparam int SIG_WRITE = 0;
    localparam int SIG_BUSY  = 1;
    localparam int SIG_ERROR = 2;
    localparam int SIG_CLKEN = 3;

    logic                 TRIGGER_CLK = 1'b0;
    logic                 RESET;
    logic                 trigger;
    logic                 trigger_flag;
    logic                 trigger_enable;
    logic                 trigger_acknowledge;
    tlu_mode_e            tlu_mode;
    logic [TIMEOUT_W-1:0] tlu_trigger_low_time_out;
    logic [CYCLES_W-1:0]  tlu_trigger_clock_cycles;
    logic [DELAY_W-1:0]   tlu_trigger_data_delay;
    logic                 tlu_trigger_data_msb_first;
    logic                 tlu_reset_flag;
    logic                 write_timestamp;
    logic                 trigger_counter_set;
    logic [DATA_W-1:0]    trigger_counter_set_value;
    logic                 trigger_data_write;
    logic [DATA_W-1:0]    trigger_data;
    logic                 trigger_accepted_flag;
    logic                 tlu_busy;
    logic                 tlu_clock_enable;
    logic                 tlu_trigger_low_timeout_error;
    logic [DATA_W-1:0]    timestamp;

    logic [31:0] lfsr_state = 32'h52ae;
    logic [31:0] tlu_number = '0;  // number sent by the TLU model
    logic [31:0] model_count = '0;
    logic [31:0] snap_count = '0;
    logic [31:0] snap_ts = '0;
    logic [31:0] expected;
    bit          write_pending = 1'b0;
    bit          timed_out = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          accepts = 0;
    int          writes = 0;
    int          errors_before;
    int          base_count;

    `include "tlu_tb_model.svh"

    tlu_controller #(
        .DIVISOR (DIVISOR)
    ) dut0 (.*);

    always #5 TRIGGER_CLK = ~TRIGGER_CLK;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            SIG_WRITE: return trigger_data_write;
            SIG_BUSY:  return tlu_busy;
            SIG_ERROR: return tlu_trigger_low_timeout_error;
            default:   return tlu_clock_enable;
        endcase
    endfunction

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            $display("Error at time %0t: %s", $time, what);
            errors++;
        end
    endtask

    // samples on falling edges and gives up after limit cycles
    task automatic wait_for(input int sel, input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge TRIGGER_CLK);
        while (!timed_out && watched(sel) !== level)
        begin
            cycles++;
            if (cycles > limit)
            begin
                $display("Timed out at %0t waiting for %s", $time, what);
                timed_out = 1'b1;
            end
            else
                @(negedge TRIGGER_CLK);
        end
    endtask

    task automatic finish_record();
        int delay;
        wait_for(SIG_WRITE, 1'b1, 700, "the record write strobe");
        expect_true(tlu_busy === 1'b1, "busy low while a record is written");
        delay = 1 + int'(rand_bits(2));
        repeat (delay) @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b1;
        trigger             <= 1'b0;  // release a line held past the timeout
        @(negedge TRIGGER_CLK);
        expect_true(tlu_busy === 1'b1, "busy fell before the acknowledge was seen");
        @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b0;
        wait_for(SIG_BUSY, 1'b0, 10, "busy to fall after the acknowledge");
    endtask

    task automatic flag_trigger(input bit stamp);
        wait_for(SIG_BUSY, 1'b0, 20, "idle before a flag trigger");
        repeat (int'(rand_bits(2))) @(posedge TRIGGER_CLK);
        @(posedge TRIGGER_CLK);
        tlu_mode        <= rand_bits(1) ? ext_flag_1 : ext_flag_0;
        write_timestamp <= stamp;
        trigger_flag    <= 1'b1;
        @(posedge TRIGGER_CLK);
        trigger_flag <= 1'b0;
        finish_record();
    endtask

    // TLU side of the mode 3 handshake
    task automatic tlu_trigger(input logic [4:0] cycles, input bit msb_first);
        int periods;
        int hold;
        int delay;
        wait_for(SIG_BUSY, 1'b0, 20, "idle before a TLU trigger");
        delay = int'(rand_bits(4));
        hold = 6 + int'(rand_bits(3)) % 7;
        periods = (cycles == 5'd0) ? TRIG_NUM_BITS : int'(cycles);
        tlu_number = rand_bits(32);
        @(posedge TRIGGER_CLK);
        tlu_mode                   <= tlu_data_handshake;
        write_timestamp            <= 1'b0;
        tlu_trigger_low_time_out   <= '0;
        tlu_trigger_clock_cycles   <= cycles;
        tlu_trigger_data_msb_first <= msb_first;
        tlu_trigger_data_delay     <= delay[DELAY_W-1:0];
        trigger                    <= 1'b1;
        repeat (hold) @(posedge TRIGGER_CLK);
        trigger <= 1'b0;
        wait_for(SIG_CLKEN, 1'b1, 60, "the TLU clock enable");
        repeat (delay + SYNC_LATCH_CYCLES) @(posedge TRIGGER_CLK);  // cable and sync delay
        for (int i = 0; i < periods * DIVISOR; i++)
        begin
            if (i > 0)
                @(posedge TRIGGER_CLK);
            // first period is the zero start bit
            trigger <= (i < DIVISOR) ? 1'b0 : serial_bit(tlu_number, cycles, msb_first,
                                                         i / DIVISOR - 1);
        end
        @(posedge TRIGGER_CLK);
        trigger <= 1'b0;
        finish_record();
    endtask

    task automatic end_test(input string name);
        $display("test %-16s %s, %0d errors", name,
                 (errors == errors_before && !timed_out) ? "ok" : "failed",
                 errors - errors_before);
        errors_before = errors;
    endtask

    // software view of the counter and the record snapshots
    always @(negedge TRIGGER_CLK)
    begin
        if (!RESET)
        begin
            if (trigger_accepted_flag)
            begin
                snap_count = model_count;
                snap_ts    = timestamp;
                accepts++;
            end
            if (trigger_counter_set)
                model_count = trigger_counter_set_value;
            else if (trigger_accepted_flag)
                model_count = model_count + 1;
            if (write_pending)
            begin
                expected = expected_word(tlu_mode, write_timestamp, snap_count, snap_ts,
                                         tlu_number, tlu_trigger_clock_cycles,
                                         tlu_trigger_data_msb_first);
                checks++;
                assert (trigger_data === expected)
                else
                begin
                    $display("Error at time %0t: record %h, expected %h", $time,
                             trigger_data, expected);
                    errors++;
                end
                write_pending = 1'b0;
            end
            if (trigger_data_write)
            begin
                write_pending = 1'b1;
                writes++;
            end
        end
    end

    initial
    begin
        RESET = 1'b1;
        tlu_reset_flag = 1'b1;
        trigger = 1'b0;
        trigger_flag = 1'b0;
        trigger_enable = 1'b1;
        trigger_acknowledge = 1'b0;
        tlu_mode = ext_flag_0;
        tlu_trigger_low_time_out = '0;
        tlu_trigger_clock_cycles = '0;
        tlu_trigger_data_delay = '0;
        tlu_trigger_data_msb_first = 1'b0;
        write_timestamp = 1'b0;
        trigger_counter_set = 1'b0;
        trigger_counter_set_value = '0;
        errors_before = 0;
        repeat (8) @(posedge TRIGGER_CLK);
        RESET          <= 1'b0;
        tlu_reset_flag <= 1'b0;

        @(negedge TRIGGER_CLK);
        expect_true({trigger_data_write, trigger_accepted_flag, tlu_busy, tlu_clock_enable,
                     tlu_trigger_low_timeout_error} === 5'b0, "control outputs high after reset");
        flag_trigger(1'b0);
        // record word holds until the next record
        expect_true(trigger_data === 32'h8000_0000, "first record did not carry count 0");
        end_test("reset_state");

        base_count = accepts - writes;
        repeat (12) flag_trigger(1'b0);
        expect_true(accepts - writes == base_count, "accepted pulses differ from records");
        end_test("trigger_count");

        @(posedge TRIGGER_CLK);
        trigger_counter_set       <= 1'b1;
        trigger_counter_set_value <= rand_bits(32);
        @(posedge TRIGGER_CLK);
        trigger_counter_set <= 1'b0;
        repeat (4) flag_trigger(1'b0);
        end_test("counter_preset");

        repeat (6) flag_trigger(1'b1);
        end_test("timestamp");

        for (int k = 0; k < 6; k++)
            tlu_trigger((k == 0) ? 5'd0 : CYCLES_W'(rand_bits(5)), k[0]);
        end_test("tlu_number");

        @(posedge TRIGGER_CLK);
        tlu_mode                 <= tlu_no_handshake;
        tlu_trigger_low_time_out <= TIMEOUT_W'(8 + rand_bits(3));
        trigger                  <= 1'b1;  // held until the acknowledge
        wait_for(SIG_ERROR, 1'b1, 40, "the low timeout error");
        finish_record();
        wait_for(SIG_ERROR, 1'b0, 5, "the low timeout error to clear in idle");
        end_test("low_timeout");

        $display("checks %0d, errors %0d, records %0d", checks, errors, writes);
        if (errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: flist.f
+incdir+dv
hw/tlu_pkg.sv
hw/tlu_sequencer.sv
hw/tlu_phase_timer.sv
hw/tlu_number_deserializer.sv
hw/trigger_record.sv
hw/tlu_controller.sv
dv/tb_tlu_controller.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tlu_controller
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)
